/* source/mem_pipe_pkg.sv */
`default_nettype none

package mem_pipe_pkg;

    // memory operation carried down from execute
    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_lb   = 4'd1,
        op_lbu  = 4'd2,
        op_lh   = 4'd3,
        op_lhu  = 4'd4,
        op_lw   = 4'd5,
        op_lwl  = 4'd6,
        op_lwr  = 4'd7,
        op_sb   = 4'd8,
        op_sh   = 4'd9,
        op_sw   = 4'd10,
        op_swl  = 4'd11,
        op_swr  = 4'd12
    } mem_op_t;

    // execute -> memory stage
    typedef struct packed {
        logic [31:0] pc;
        mem_op_t     op;
        logic [1:0]  addr_low;   // byte offset inside the word
        logic [31:0] alu_result;
        logic [31:0] rt_value;   // store data, or merge base for lwl/lwr
        logic        gr_we;
        logic [4:0]  dest;
        logic        ex;
    } ms_payload_t;

    // memory -> write-back stage
    typedef struct packed {
        logic [31:0] pc;
        logic        gr_we;
        logic [4:0]  dest;
        logic [31:0] result;
        logic        ex;
    } ws_payload_t;

    function automatic logic is_load(input mem_op_t op);
        return op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwl, op_lwr};
    endfunction

    function automatic logic is_store(input mem_op_t op);
        return op inside {op_sb, op_sh, op_sw, op_swl, op_swr};
    endfunction

endpackage

`default_nettype wire

/* source/stage_latch.sv */
`timescale 1ns/1ns
`default_nettype none

module stage_latch #(
    parameter type payload_t = logic
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic flush,
    input  wire logic in_valid,
    input  payload_t  in_payload,
    input  wire logic out_allowin,  // allowin of the next stage
    output logic      allowin,
    output logic      valid,
    output payload_t  payload
);

    logic accept;

    // ready_go is always high, so the item leaves whenever downstream takes it
    // nothing enters while a flush is in progress
    assign allowin = (!valid || out_allowin) && !flush;
    assign accept  = in_valid && allowin;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid <= 1'b0;
        end else if (allowin) begin
            valid <= in_valid;  // goes empty when the item leaves with nothing behind it
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            payload <= '0;
        end else if (accept) begin
            payload <= in_payload;
        end
    end

endmodule

`default_nettype wire

/* source/store_align.sv */
`timescale 1ns/1ns
`default_nettype none

module store_align import mem_pipe_pkg::*; (
    input  mem_op_t          op,
    input  wire logic [1:0]  addr_low,
    input  wire logic [31:0] rt_value,
    output logic      [3:0]  byte_en,
    output logic      [31:0] wdata
);

    logic [4:0] lo_shift;  // bit shift for swr, offset * 8
    logic [4:0] hi_shift;  // bit shift for swl, (3 - offset) * 8

    assign lo_shift = {addr_low, 3'b000};
    assign hi_shift = {~addr_low, 3'b000};

    always_comb begin
        byte_en = 4'b0000;
        wdata   = 32'd0;
        case (op)
            op_sb: begin
                byte_en = 4'b0001 << addr_low;
                wdata   = {4{rt_value[7:0]}};  // byte copied to every lane
            end
            op_sh: begin
                byte_en = addr_low[1] ? 4'b1100 : 4'b0011;
                wdata   = {2{rt_value[15:0]}};
            end
            op_sw: begin
                byte_en = 4'b1111;
                wdata   = rt_value;
            end
            op_swl: begin
                // lanes 0..offset take the top bytes of rt
                byte_en = 4'b1111 >> (~addr_low);
                wdata   = rt_value >> hi_shift;
            end
            op_swr: begin
                // lanes offset..3 take the bottom bytes of rt
                byte_en = 4'b1111 << addr_low;
                wdata   = rt_value << lo_shift;
            end
            default: begin
                byte_en = 4'b0000;  // loads and alu ops never write
                wdata   = 32'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/data_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module data_ram #(
    parameter int ram_addr_bits = 10
) (
    input  wire logic                     clk,
    input  wire logic                     we,
    input  wire logic [3:0]               byte_en,
    input  wire logic [ram_addr_bits-1:0] addr,     // word address
    input  wire logic [31:0]              wdata,
    input  wire logic                     re,
    output logic      [31:0]              rdata
);

    localparam int depth = 2 ** ram_addr_bits;

    logic [31:0] mem [0:depth-1];

    // byte lane writes
    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // read register, old word on a same-address write
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* source/load_align.sv */
`timescale 1ns/1ns
`default_nettype none

module load_align import mem_pipe_pkg::*; (
    input  mem_op_t          op,
    input  wire logic [1:0]  addr_low,
    input  wire logic [31:0] rdata,
    input  wire logic [31:0] rt_value,
    output logic      [31:0] load_data
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic [31:0] lwl_data;
    logic [31:0] lwr_data;

    // lane picked by the byte offset
    always_comb begin
        case (addr_low)
            2'd0:    byte_sel = rdata[7:0];
            2'd1:    byte_sel = rdata[15:8];
            2'd2:    byte_sel = rdata[23:16];
            default: byte_sel = rdata[31:24];
        endcase
    end

    assign half_sel = addr_low[1] ? rdata[31:16] : rdata[15:0];

    // lwl: low ram bytes land in the top of rt
    always_comb begin
        case (addr_low)
            2'd0:    lwl_data = {rdata[7:0], rt_value[23:0]};
            2'd1:    lwl_data = {rdata[15:0], rt_value[15:0]};
            2'd2:    lwl_data = {rdata[23:0], rt_value[7:0]};
            default: lwl_data = rdata;
        endcase
    end

    // lwr: high ram bytes land in the bottom of rt
    always_comb begin
        case (addr_low)
            2'd0:    lwr_data = rdata;
            2'd1:    lwr_data = {rt_value[31:24], rdata[31:8]};
            2'd2:    lwr_data = {rt_value[31:16], rdata[31:16]};
            default: lwr_data = {rt_value[31:8], rdata[31:24]};
        endcase
    end

    always_comb begin
        case (op)
            op_lb:   load_data = {{24{byte_sel[7]}}, byte_sel};
            op_lbu:  load_data = {24'd0, byte_sel};
            op_lh:   load_data = {{16{half_sel[15]}}, half_sel};
            op_lhu:  load_data = {16'd0, half_sel};
            op_lwl:  load_data = lwl_data;
            op_lwr:  load_data = lwr_data;
            default: load_data = rdata;  // lw
        endcase
    end

endmodule

`default_nettype wire

/* source/mem_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_stage import mem_pipe_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        flush,
    input  wire logic        es_valid,
    input  ms_payload_t      es_payload,
    input  wire logic        ws_allowin,
    output logic             ms_allowin,
    output logic             ms_to_ws_valid,
    output ws_payload_t      ms_to_ws_payload,
    input  wire logic [31:0] ram_rdata,
    output logic      [4:0]  fwd_dest,
    output logic      [31:0] fwd_result
);

    logic        ms_valid;
    ms_payload_t ms_payload;
    logic [31:0] load_data;
    logic [31:0] final_result;

    stage_latch #(
        .payload_t (ms_payload_t)
    ) u_latch (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .in_valid    (es_valid),
        .in_payload  (es_payload),
        .out_allowin (ws_allowin),
        .allowin     (ms_allowin),
        .valid       (ms_valid),
        .payload     (ms_payload)
    );

    load_align u_load_align (
        .op        (ms_payload.op),
        .addr_low  (ms_payload.addr_low),
        .rdata     (ram_rdata),
        .rt_value  (ms_payload.rt_value),
        .load_data (load_data)
    );

    assign final_result = is_load(ms_payload.op) ? load_data : ms_payload.alu_result;

    assign ms_to_ws_valid = ms_valid && !flush;  // a flushed item never reaches write-back

    always_comb begin
        ms_to_ws_payload.pc     = ms_payload.pc;
        ms_to_ws_payload.gr_we  = ms_payload.gr_we;
        ms_to_ws_payload.dest   = ms_payload.dest;
        ms_to_ws_payload.result = final_result;
        ms_to_ws_payload.ex     = ms_payload.ex;
    end

    // bypass to decode
    assign fwd_dest   = ms_valid ? ms_payload.dest : 5'd0;
    assign fwd_result = final_result;

endmodule

`default_nettype wire

/* source/wb_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module wb_stage import mem_pipe_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        ms_valid,
    input  ws_payload_t      ms_payload,
    input  wire logic        wb_ready,
    output logic             ws_allowin,
    output logic             ws_valid,
    output logic             ws_we,
    output logic      [4:0]  ws_dest,
    output logic      [31:0] ws_wdata,
    output logic      [31:0] ws_pc,
    output logic             ws_ex
);

    ws_payload_t ws_payload;

    // the sink's ready acts as the next stage's allowin
    stage_latch #(
        .payload_t (ws_payload_t)
    ) u_latch (
        .clk         (clk),
        .reset       (reset),
        .flush       (1'b0),
        .in_valid    (ms_valid),
        .in_payload  (ms_payload),
        .out_allowin (wb_ready),
        .allowin     (ws_allowin),
        .valid       (ws_valid),
        .payload     (ws_payload)
    );

    // excepting instruction retires without touching the register file
    assign ws_we    = ws_valid && ws_payload.gr_we && !ws_payload.ex;
    assign ws_ex    = ws_valid && ws_payload.ex;
    assign ws_dest  = ws_payload.dest;
    assign ws_wdata = ws_payload.result;
    assign ws_pc    = ws_payload.pc;

endmodule

`default_nettype wire

/* source/mem_access_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_access_top import mem_pipe_pkg::*; #(
    parameter int ram_addr_bits = 10
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        es_valid,
    input  wire logic [31:0] es_pc,
    input  mem_op_t          es_op,
    input  wire logic [31:0] es_alu_result,  // effective address or alu value
    input  wire logic [31:0] es_rt_value,
    input  wire logic        es_gr_we,
    input  wire logic [4:0]  es_dest,
    input  wire logic        es_ex,
    input  wire logic        flush,
    input  wire logic        wb_ready,
    output logic             es_allowin,
    output logic      [4:0]  ms_fwd_dest,
    output logic      [31:0] ms_fwd_result,
    output logic             ws_valid,
    output logic             ws_we,
    output logic      [4:0]  ws_dest,
    output logic      [31:0] ws_wdata,
    output logic      [31:0] ws_pc,
    output logic             ws_ex
);

    logic        ms_allowin;
    logic        ws_allowin;
    logic        accept;
    logic        ram_we;
    logic        ram_re;
    logic [3:0]  byte_en;
    logic [31:0] ram_wdata;
    logic [31:0] ram_rdata;
    ms_payload_t es_payload;
    logic        ms_to_ws_valid;
    ws_payload_t ms_to_ws_payload;

    assign es_allowin = ms_allowin;
    assign accept     = es_valid && ms_allowin;

    // an excepting store must leave memory alone
    assign ram_we = accept && is_store(es_op) && !es_ex && !flush;
    assign ram_re = accept && is_load(es_op);  // held otherwise so a stalled load keeps its word

    store_align u_store_align (
        .op       (es_op),
        .addr_low (es_alu_result[1:0]),
        .rt_value (es_rt_value),
        .byte_en  (byte_en),
        .wdata    (ram_wdata)
    );

    data_ram #(
        .ram_addr_bits (ram_addr_bits)
    ) u_data_ram (
        .clk     (clk),
        .we      (ram_we),
        .byte_en (byte_en),
        .addr    (es_alu_result[ram_addr_bits+1:2]),
        .wdata   (ram_wdata),
        .re      (ram_re),
        .rdata   (ram_rdata)
    );

    always_comb begin
        es_payload.pc         = es_pc;
        es_payload.op         = es_op;
        es_payload.addr_low   = es_alu_result[1:0];
        es_payload.alu_result = es_alu_result;
        es_payload.rt_value   = es_rt_value;
        es_payload.gr_we      = es_gr_we;
        es_payload.dest       = es_dest;
        es_payload.ex         = es_ex;
    end

    mem_stage u_mem_stage (
        .clk              (clk),
        .reset            (reset),
        .flush            (flush),
        .es_valid         (es_valid),
        .es_payload       (es_payload),
        .ws_allowin       (ws_allowin),
        .ms_allowin       (ms_allowin),
        .ms_to_ws_valid   (ms_to_ws_valid),
        .ms_to_ws_payload (ms_to_ws_payload),
        .ram_rdata        (ram_rdata),
        .fwd_dest         (ms_fwd_dest),
        .fwd_result       (ms_fwd_result)
    );

    wb_stage u_wb_stage (
        .clk        (clk),
        .reset      (reset),
        .ms_valid   (ms_to_ws_valid),
        .ms_payload (ms_to_ws_payload),
        .wb_ready   (wb_ready),
        .ws_allowin (ws_allowin),
        .ws_valid   (ws_valid),
        .ws_we      (ws_we),
        .ws_dest    (ws_dest),
        .ws_wdata   (ws_wdata),
        .ws_pc      (ws_pc),
        .ws_ex      (ws_ex)
    );

endmodule

`default_nettype wire

/* sim/mem_access_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_stage_sva import mem_pipe_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       flush,
    input  wire logic       ms_valid,
    input  ms_payload_t     ms_payload,
    input  wire logic       ws_allowin,
    input  wire logic [4:0] fwd_dest
);

    int fail_count = 0;  // read by the testbench at the end

    // held item must not change under back-pressure
    assert property (@(posedge clk) disable iff (reset)
        ms_valid && !ws_allowin && !flush |=> $stable(ms_payload))
        else begin
            $error("memory stage payload changed while stalled");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (reset) flush |=> !ms_valid)
        else begin
            $error("memory stage still valid after flush");
            fail_count++;
        end

    // no bypass from an empty stage
    assert property (@(posedge clk) disable iff (reset) !ms_valid |-> fwd_dest == 5'd0)
        else begin
            $error("forward destination nonzero while memory stage empty");
            fail_count++;
        end

endmodule

bind mem_stage mem_stage_sva u_sva (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .ms_valid   (ms_valid),
    .ms_payload (ms_payload),
    .ws_allowin (ws_allowin),
    .fwd_dest   (fwd_dest)
);

`default_nettype wire

/* sim/mem_access_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_access_tb import mem_pipe_pkg::*; ();

    localparam int max_cycles = 4000;

    typedef struct packed {
        logic [31:0] pc;
        logic        we;
        logic [4:0]  dest;
        logic [31:0] wdata;
        logic        ex;
    } retire_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        es_valid;
    logic [31:0] es_pc;
    mem_op_t     es_op;
    logic [31:0] es_alu_result;
    logic [31:0] es_rt_value;
    logic        es_gr_we;
    logic [4:0]  es_dest;
    logic        es_ex;
    logic        flush;
    logic        wb_ready = 1'b1;
    logic        es_allowin;
    logic [4:0]  ms_fwd_dest;
    logic [31:0] ms_fwd_result;
    logic        ws_valid;
    logic        ws_we;
    logic [4:0]  ws_dest;
    logic [31:0] ws_wdata;
    logic [31:0] ws_pc;
    logic        ws_ex;

    logic [31:0] model_mem [0:15];  // words 0..15 of the data RAM
    retire_t     exp_q [$];
    string       name_q [$];
    string       test_name = "reset";
    int          check_errors = 0;
    int          cycles = 0;
    logic        ms_occ = 1'b0;  // expected stage occupancy
    logic        ws_occ = 1'b0;
    logic        stall_phase = 1'b0;
    logic [31:0] next_pc = 32'h0040_0000;

    always #2 clk = ~clk;

    mem_access_top #(
        .ram_addr_bits (10)
    ) u_dut (
        .clk (clk), .reset (reset), .es_valid (es_valid), .es_pc (es_pc), .es_op (es_op),
        .es_alu_result (es_alu_result), .es_rt_value (es_rt_value), .es_gr_we (es_gr_we),
        .es_dest (es_dest), .es_ex (es_ex), .flush (flush), .wb_ready (wb_ready),
        .es_allowin (es_allowin), .ms_fwd_dest (ms_fwd_dest), .ms_fwd_result (ms_fwd_result),
        .ws_valid (ws_valid), .ws_we (ws_we), .ws_dest (ws_dest), .ws_wdata (ws_wdata),
        .ws_pc (ws_pc), .ws_ex (ws_ex)
    );

    task automatic report_mismatch(input string tname, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("[ERROR] %s %s: expected %h, actual %h", tname, what, expected, actual);
        check_errors++;
    endtask

    function automatic logic [31:0] word_addr(input int w, input int k);
        return {26'd0, 4'(w), 2'(k)};
    endfunction

    function automatic logic [31:0] expected_load(input mem_op_t op, input logic [31:0] addr,
                                                  input logic [31:0] rt);
        logic [31:0] w;
        logic [31:0] lane;
        int          k;
        k    = int'(addr[1:0]);
        w    = model_mem[addr[5:2]];
        lane = w >> (8 * k);  // addressed byte or half now in the low bits
        case (op)
            op_lb:   return {{24{lane[7]}}, lane[7:0]};
            op_lbu:  return {24'd0, lane[7:0]};
            op_lh:   return {{16{lane[15]}}, lane[15:0]};
            op_lhu:  return {16'd0, lane[15:0]};
            op_lwl:  return (w << (8 * (3 - k))) | (rt & (32'hffff_ffff >> (8 * (k + 1))));
            op_lwr:  return lane | (rt & ~(32'hffff_ffff >> (8 * k)));
            default: return w;
        endcase
    endfunction

    function automatic void apply_store(input mem_op_t op, input logic [31:0] addr,
                                        input logic [31:0] rt);
        logic [31:0] mask;
        logic [31:0] data;
        int          k;
        k = int'(addr[1:0]);
        case (op)
            op_sb: begin
                mask = 32'h0000_00ff << (8 * k);
                data = rt << (8 * k);
            end
            op_sh: begin
                mask = 32'h0000_ffff << (8 * k);
                data = rt << (8 * k);
            end
            op_swl: begin
                mask = 32'hffff_ffff >> (8 * (3 - k));
                data = rt >> (8 * (3 - k));
            end
            op_swr: begin
                mask = 32'hffff_ffff << (8 * k);
                data = rt << (8 * k);
            end
            default: begin  // sw
                mask = 32'hffff_ffff;
                data = rt;
            end
        endcase
        model_mem[addr[5:2]] = (model_mem[addr[5:2]] & ~mask) | (data & mask);
    endfunction

    function automatic logic [4:0] rand_dest();
        return 5'(1 + ($urandom % 31));
    endfunction

    task automatic offer(input mem_op_t op, input logic [31:0] alu, input logic [31:0] rt,
                         input logic gr_we, input logic [4:0] dest, input logic ex);
        es_valid      <= 1'b1;
        es_pc         <= next_pc;
        es_op         <= op;
        es_alu_result <= alu;
        es_rt_value   <= rt;
        es_gr_we      <= gr_we;
        es_dest       <= dest;
        es_ex         <= ex;
        next_pc = next_pc + 32'd4;
    endtask

    task automatic wait_accept();
        do @(posedge clk); while (!es_allowin);
        es_valid <= 1'b0;
    endtask

    task automatic issue(input mem_op_t op, input logic [31:0] alu, input logic [31:0] rt,
                         input logic gr_we, input logic [4:0] dest, input logic ex);
        offer(op, alu, rt, gr_we, dest, ex);
        wait_accept();
    endtask

    task automatic load_op(input mem_op_t op, input logic [31:0] addr, input logic [31:0] rt);
        issue(op, addr, rt, 1'b1, rand_dest(), 1'b0);
    endtask

    task automatic store_op(input mem_op_t op, input logic [31:0] addr, input logic [31:0] rt,
                            input logic ex);
        issue(op, addr, rt, 1'b0, 5'd0, ex);
    endtask

    task automatic random_instr();
        logic [31:0] r;
        mem_op_t     op;
        logic [1:0]  off;
        r   = $urandom;
        op  = mem_op_t'(4'(r % 13));
        off = r[5:4];
        if (op inside {op_lh, op_lhu, op_sh}) off[0] = 1'b0;  // halves stay aligned
        if (op inside {op_lw, op_sw}) off = 2'b00;
        issue(op, (op == op_none) ? $urandom : {26'd0, r[9:6], off}, $urandom,
              !(op inside {op_sb, op_sh, op_sw, op_swl, op_swr}), rand_dest(), r[12:10] == 3'd0);
    endtask

    // random back-pressure from the register-file side
    always @(posedge clk) begin
        logic [31:0] rnd;
        rnd = $urandom;
        wb_ready <= stall_phase ? rnd[0] : 1'b1;
    end

    // reference pipeline model, checked every cycle
    always @(posedge clk) begin
        retire_t rec;
        string   tname;
        logic    ws_allow;
        logic    ms_allow;
        logic    ms_leave;
        logic    accept;
        if (reset) begin
            ms_occ = 1'b0;
            ws_occ = 1'b0;
        end else begin
            ws_allow = !ws_occ || wb_ready;
            ms_allow = (!ms_occ || ws_allow) && !flush;
            ms_leave = ms_occ && ws_allow && !flush;
            accept   = es_valid && ms_allow;
            assert (es_allowin == ms_allow)
                else report_mismatch(test_name, "es_allowin", 32'(ms_allow), 32'(es_allowin));
            assert (ws_valid == ws_occ)
                else report_mismatch(test_name, "ws_valid", 32'(ws_occ), 32'(ws_valid));
            if (ms_occ && exp_q.size() > 0) begin
                rec = exp_q[$];  // newest item sits in the memory stage
                assert (ms_fwd_dest == rec.dest)
                    else report_mismatch(test_name, "fwd_dest", 32'(rec.dest), 32'(ms_fwd_dest));
                assert (ms_fwd_result == rec.wdata)
                    else report_mismatch(test_name, "fwd_result", rec.wdata, ms_fwd_result);
            end else begin
                assert (ms_fwd_dest == 5'd0)
                    else report_mismatch(test_name, "fwd_dest idle", 32'd0, 32'(ms_fwd_dest));
            end
            if (ws_occ && wb_ready && exp_q.size() > 0) begin
                rec   = exp_q.pop_front();
                tname = name_q.pop_front();
                assert (ws_pc == rec.pc) else report_mismatch(tname, "pc", rec.pc, ws_pc);
                assert (ws_wdata == rec.wdata)
                    else report_mismatch(tname, "wdata", rec.wdata, ws_wdata);
                assert ({ws_we, ws_ex, ws_dest} == {rec.we, rec.ex, rec.dest})
                    else report_mismatch(tname, "we/ex/dest", 32'({rec.we, rec.ex, rec.dest}),
                                         32'({ws_we, ws_ex, ws_dest}));
            end
            if (flush && ms_occ && exp_q.size() > 0) begin
                rec   = exp_q.pop_back();  // flushed item never retires
                tname = name_q.pop_back();
            end
            if (accept) begin
                rec.pc    = es_pc;
                rec.we    = es_gr_we && !es_ex;
                rec.dest  = es_dest;
                rec.ex    = es_ex;
                rec.wdata = es_alu_result;
                if (es_op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwl, op_lwr})
                    rec.wdata = expected_load(es_op, es_alu_result, es_rt_value);
                if (es_op inside {op_sb, op_sh, op_sw, op_swl, op_swr} && !es_ex)
                    apply_store(es_op, es_alu_result, es_rt_value);
                exp_q.push_back(rec);
                name_q.push_back(test_name);
            end
            ws_occ = ms_leave || (ws_occ && !wb_ready);
            ms_occ = accept || (ms_occ && !ms_leave && !flush);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(57333));
        reset <= 1'b1;
        es_valid <= 1'b0;
        es_pc <= 32'd0;
        es_op <= op_none;
        es_alu_result <= 32'd0;
        es_rt_value <= 32'd0;
        es_gr_we <= 1'b0;
        es_dest <= 5'd0;
        es_ex <= 1'b0;
        flush <= 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        assert ({ws_valid, ws_we, ms_fwd_dest, es_allowin} == 8'h01)
            else report_mismatch("reset", "idle state", 32'h1,
                                 32'({ws_valid, ws_we, ms_fwd_dest, es_allowin}));

        test_name = "prefill";
        for (int i = 0; i < 16; i++) store_op(op_sw, word_addr(i, 0), $urandom, 1'b0);

        test_name = "store_load";
        store_op(op_sw, word_addr(8, 0), 32'hcafe_f00d, 1'b0);
        load_op(op_lw, word_addr(8, 0), 32'd0);
        test_name = "alu_only";
        issue(op_none, 32'h1234_5678, 32'd0, 1'b1, 5'd9, 1'b0);

        test_name = "sub_word_loads";
        for (int w = 0; w < 4; w++) begin
            for (int k = 0; k < 4; k++) begin
                load_op(op_lb, word_addr(w, k), $urandom);
                load_op(op_lbu, word_addr(w, k), $urandom);
                if (k % 2 == 0) begin
                    load_op(op_lh, word_addr(w, k), $urandom);
                    load_op(op_lhu, word_addr(w, k), $urandom);
                end
            end
        end

        test_name = "partial_word";
        for (int k = 0; k < 4; k++) begin
            load_op(op_lwl, word_addr(3, k), $urandom);
            load_op(op_lwr, word_addr(4, k), $urandom);
            store_op(op_sb, word_addr(5, k), $urandom, 1'b0);
            load_op(op_lw, word_addr(5, 0), 32'd0);
            store_op(op_swl, word_addr(6, k), $urandom, 1'b0);
            load_op(op_lw, word_addr(6, 0), 32'd0);
            store_op(op_swr, word_addr(7, k), $urandom, 1'b0);
            load_op(op_lw, word_addr(7, 0), 32'd0);
            if (k % 2 == 0) begin
                store_op(op_sh, word_addr(9, k), $urandom, 1'b0);
                load_op(op_lw, word_addr(9, 0), 32'd0);
            end
        end

        test_name = "ex_store";
        store_op(op_sw, word_addr(10, 0), $urandom, 1'b1);
        load_op(op_lw, word_addr(10, 0), 32'd0);

        test_name = "random_stall";
        stall_phase <= 1'b1;
        repeat (200) random_instr();
        stall_phase <= 1'b0;

        test_name = "flush";
        load_op(op_lw, word_addr(2, 0), 32'd0);
        flush <= 1'b1;  // load is now in the memory stage
        offer(op_lbu, word_addr(2, 1), 32'd0, 1'b1, 5'd7, 1'b0);
        @(posedge clk);
        flush <= 1'b0;
        wait_accept();
        load_op(op_lh, word_addr(2, 2), 32'd0);

        while (exp_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        $display("errors: %0d check, %0d assertion", check_errors,
                 u_dut.u_mem_stage.u_sva.fail_count);
        if (check_errors == 0 && u_dut.u_mem_stage.u_sva.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mem_pipe.f */
source/mem_pipe_pkg.sv
source/stage_latch.sv
source/store_align.sv
source/data_ram.sv
source/load_align.sv
source/mem_stage.sv
source/wb_stage.sv
source/mem_access_top.sv
sim/mem_access_sva.sv
sim/mem_access_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the memory-access pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --timescale 1ns/1ns \
    --top-module mem_access_tb -f mem_pipe.f

out=$(./obj_dir/Vmem_access_tb +verilator+error+limit+100 || true)
echo "$out"

if echo "$out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1
